//--- design/t08_alu.sv
`timescale 1ns/1ps

module t08_alu (
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  t08_pkg::alu_op_t  op,
    output logic [31:0]       y
);

    logic [4:0] shamt; // Shift amount from the low bits of b

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            t08_pkg::alu_add: y = a + b;
            t08_pkg::alu_sub: y = a - b;
            t08_pkg::alu_and: y = a & b;
            t08_pkg::alu_or:  y = a | b;
            t08_pkg::alu_xor: y = a ^ b;
            t08_pkg::alu_sll: y = a << shamt;
            t08_pkg::alu_srl: y = a >> shamt; // Logical, zero fill
            t08_pkg::alu_slt: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:          y = '0;
        endcase
    end

endmodule

//--- design/t08_decoder.sv
`timescale 1ns/1ps

module t08_decoder (
    input  t08_pkg::instr_t   instr,
    output logic [4:0]        rs1,
    output logic [4:0]        rs2,
    output logic [4:0]        rd,
    output logic [31:0]       imm,
    output logic              use_imm,
    output logic              uses_rs2,
    output t08_pkg::alu_op_t  alu_op,
    output t08_pkg::wb_src_t  wb_src
);

    logic [31:0] imm_i; // Sign-extended I-type immediate

    function automatic t08_pkg::alu_op_t map_funct(input logic [2:0] funct3,
                                                   input logic       is_sub);
        case (funct3)
            t08_pkg::funct3_add_sub: map_funct = is_sub ? t08_pkg::alu_sub : t08_pkg::alu_add;
            t08_pkg::funct3_sll:     map_funct = t08_pkg::alu_sll;
            t08_pkg::funct3_slt:     map_funct = t08_pkg::alu_slt;
            t08_pkg::funct3_xor:     map_funct = t08_pkg::alu_xor;
            t08_pkg::funct3_srl:     map_funct = t08_pkg::alu_srl;
            t08_pkg::funct3_or:      map_funct = t08_pkg::alu_or;
            t08_pkg::funct3_and:     map_funct = t08_pkg::alu_and;
            default:                 map_funct = t08_pkg::alu_add; // sltu not supported
        endcase
    endfunction

    assign imm_i = {{20{instr.i_type.imm12[11]}}, instr.i_type.imm12};

    always_comb begin
        rs1      = instr.r_type.rs1; // Same bits in both views
        rs2      = instr.r_type.rs2;
        rd       = instr.r_type.rd;
        imm      = '0;
        use_imm  = 1'b0;
        uses_rs2 = 1'b0;
        alu_op   = t08_pkg::alu_add;
        wb_src   = t08_pkg::wb_alu;

        case (instr.r_type.opcode)
            t08_pkg::opcode_op: begin
                uses_rs2 = 1'b1;
                alu_op   = map_funct(instr.r_type.funct3,
                                     instr.r_type.funct7 == t08_pkg::funct7_sub);
            end
            t08_pkg::opcode_op_imm: begin
                imm     = imm_i;
                use_imm = 1'b1;
                alu_op  = map_funct(instr.i_type.funct3, 1'b0); // No subi
            end
            t08_pkg::opcode_load: begin
                imm     = imm_i;
                use_imm = 1'b1;
                wb_src  = t08_pkg::wb_memory; // ALU result unused, data comes from mem_data
            end
            t08_pkg::opcode_jal: begin
                wb_src = t08_pkg::wb_fetch; // rd gets pc + 4
            end
            default: begin
                rd = 5'd0; // Unknown opcode retires with no effect
            end
        endcase
    end

endmodule

//--- design/t08_execute_unit.sv
`timescale 1ns/1ps

module t08_execute_unit (
    input  logic        clk,
    input  logic        nRst,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [31:0] mem_data,
    output logic        busy,
    output logic        done,
    output logic [31:0] result
);

    t08_pkg::instr_t   instr_held;
    t08_pkg::alu_op_t  alu_op;
    t08_pkg::wb_src_t  wb_src;
    logic [4:0]        rs1, rs2, rd;
    logic [31:0]       imm;
    logic              use_imm, uses_rs2;
    logic              en_read_1, en_read_2, en_write;
    logic [31:0]       link;
    logic [31:0]       data_out_r1, data_out_r2;
    logic [31:0]       operand_b;
    logic [31:0]       alu_y;
    logic [31:0]       wb_value;

    assign operand_b = use_imm ? imm : data_out_r2;

    // Mirrors the register file's write source select for result
    always_comb begin
        case (wb_src)
            t08_pkg::wb_memory: wb_value = mem_data;
            t08_pkg::wb_fetch:  wb_value = link;
            t08_pkg::wb_alu:    wb_value = alu_y;
            default:            wb_value = '0;
        endcase
    end

    t08_sequencer t08_sequencer_inst (
        .clk(clk), .nRst(nRst), .instr_valid(instr_valid),
        .instr_in(instr), .pc(pc), .uses_rs2(uses_rs2), .wb_value(wb_value),
        .instr_held(instr_held), .link(link),
        .en_read_1(en_read_1), .en_read_2(en_read_2), .en_write(en_write),
        .busy(busy), .done(done), .result(result)
    );

    t08_decoder t08_decoder_inst (
        .instr(instr_held), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .use_imm(use_imm), .uses_rs2(uses_rs2), .alu_op(alu_op), .wb_src(wb_src)
    );

    t08_registers t08_registers_inst (
        .clk(clk), .nRst(nRst),
        .address_r1(rs1), .address_r2(rs2), .address_rd(rd),
        .data_in_frommemory(mem_data), .data_in_frominstructionfetch(link),
        .data_in_fromalu(alu_y), .data_in_control(wb_src),
        .en_read_1(en_read_1), .en_read_2(en_read_2), .en_write(en_write),
        .data_out_r1(data_out_r1), .data_out_r2(data_out_r2)
    );

    t08_alu t08_alu_inst (
        .a(data_out_r1), .b(operand_b), .op(alu_op), .y(alu_y)
    );

endmodule

//--- design/t08_pkg.sv
package t08_pkg;

    // Opcode field values
    localparam logic [6:0] opcode_op     = 7'b0110011; // R-type arithmetic
    localparam logic [6:0] opcode_op_imm = 7'b0010011; // I-type arithmetic
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_jal    = 7'b1101111;

    // funct3 values for the arithmetic group
    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_sll     = 3'b001;
    localparam logic [2:0] funct3_slt     = 3'b010;
    localparam logic [2:0] funct3_xor     = 3'b100;
    localparam logic [2:0] funct3_srl     = 3'b101;
    localparam logic [2:0] funct3_or      = 3'b110;
    localparam logic [2:0] funct3_and     = 3'b111;

    localparam logic [6:0] funct7_sub = 7'b0100000; // Selects sub over add in R-type

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_slt
    } alu_op_t;

    // Register file write source select
    typedef enum logic [1:0] {
        wb_none   = 2'd0, // Writes zero, never enabled
        wb_memory = 2'd1,
        wb_fetch  = 2'd2,
        wb_alu    = 2'd3
    } wb_src_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // One instruction word, two field layouts
    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
    } instr_t;

endpackage

//--- design/t08_registers.sv
`timescale 1ns/1ps

module t08_registers (
    input  logic                clk,
    input  logic                nRst,
    input  logic [4:0]          address_r1,
    input  logic [4:0]          address_r2,
    input  logic [4:0]          address_rd,
    input  logic [31:0]         data_in_frommemory,
    input  logic [31:0]         data_in_frominstructionfetch,
    input  logic [31:0]         data_in_fromalu,
    input  t08_pkg::wb_src_t    data_in_control,
    input  logic                en_read_1,
    input  logic                en_read_2,
    input  logic                en_write,
    output logic [31:0]         data_out_r1,
    output logic [31:0]         data_out_r2
);

    logic [31:0]        data_in;     // Selected write data
    logic [31:0]        data_out_r1_n;
    logic [31:0]        data_out_r2_n;
    logic [31:0][31:0]  data;        // Register array
    logic [31:0][31:0]  data_n;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            data_out_r1 <= '0;
            data_out_r2 <= '0;
            data        <= '0;
        end else begin
            data_out_r1 <= data_out_r1_n;
            data_out_r2 <= data_out_r2_n;
            data        <= data_n;
        end
    end

    always_comb begin : select_data_in
        case (data_in_control)
            t08_pkg::wb_memory: data_in = data_in_frommemory;
            t08_pkg::wb_fetch:  data_in = data_in_frominstructionfetch; // Link value
            t08_pkg::wb_alu:    data_in = data_in_fromalu;
            default:            data_in = '0;
        endcase
    end

    always_comb begin : read_ports
        data_out_r1_n = en_read_1 ? data[address_r1] : data_out_r1; // Hold when not enabled
        data_out_r2_n = en_read_2 ? data[address_r2] : data_out_r2;
    end

    // Full copy first, then the single write; x0 stays zero
    always_comb begin : write_port
        data_n = data;
        if (en_write && (address_rd != 5'd0)) begin
            data_n[address_rd] = data_in;
        end
    end

endmodule

//--- design/t08_sequencer.sv
`timescale 1ns/1ps

module t08_sequencer (
    input  logic             clk,
    input  logic             nRst,
    input  logic             instr_valid,
    input  logic [31:0]      instr_in,
    input  logic [31:0]      pc,
    input  logic             uses_rs2,
    input  logic [31:0]      wb_value,
    output t08_pkg::instr_t  instr_held,
    output logic [31:0]      link,
    output logic             en_read_1,
    output logic             en_read_2,
    output logic             en_write,
    output logic             busy,
    output logic             done,
    output logic [31:0]      result
);

    // Execute is the cycle where the ALU settles and write-back is enabled
    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_execute
    } state_t;

    state_t      state;
    state_t      state_n;
    logic [31:0] pc_held;

    always_comb begin
        case (state)
            st_idle:    state_n = instr_valid ? st_read : st_idle; // Strobe only sampled here
            st_read:    state_n = st_execute;
            st_execute: state_n = st_idle;
            default:    state_n = st_idle;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state      <= st_idle;
            instr_held <= '0;
            pc_held    <= '0;
            done       <= 1'b0;
            result     <= '0;
        end else begin
            state <= state_n;
            done  <= (state == st_execute); // High for the cycle after write-back
            if (state == st_idle && instr_valid) begin
                instr_held <= instr_in;
                pc_held    <= pc;
            end
            if (state == st_execute) begin
                result <= wb_value; // Same value the register file takes
            end
        end
    end

    assign link      = pc_held + 32'd4;
    assign busy      = (state != st_idle);
    assign en_read_1 = (state == st_read);
    assign en_read_2 = (state == st_read) && uses_rs2;
    assign en_write  = (state == st_execute);

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module t08_execute_unit_tb -o t08_sim
./obj_dir/t08_sim > sim.log
cat sim.log

if grep -qx "test passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

//--- tests/t08_execute_unit_tb.sv
`timescale 1ns/1ps

module t08_execute_unit_tb;

    localparam int instr_budget    = 200;                        // Upper bound on issued instructions
    localparam int watchdog_cycles = 4 + instr_budget * 5 + 200;
    localparam logic [14:0] imm_ops = {3'b010, 3'b111, 3'b110, 3'b100, 3'b000}; // addi..slti
    localparam logic [23:0] reg_ops = {3'b111, 3'b110, 3'b101, 3'b100,
                                       3'b010, 3'b001, 3'b000, 3'b000}; // Slot 1 is sub

    logic        clk;
    logic        nRst;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] mem_data;
    logic        busy;
    logic        done;
    logic [31:0] result;

    logic [31:0] model [32];      // Expected register contents
    integer      seed = 32'h429d948c;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    t08_execute_unit t08_execute_unit_inst (
        .clk(clk), .nRst(nRst), .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .mem_data(mem_data), .busy(busy), .done(done), .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: simulation ran past %0d cycles", watchdog_cycles);
        $display("test failed");
        $finish;
    end

    function automatic logic [31:0] r_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] funct3,
                                           input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, t08_pkg::opcode_op};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] opcode, input logic [11:0] imm12,
                                           input logic [4:0] rs1, input logic [2:0] funct3,
                                           input logic [4:0] rd);
        return {imm12, rs1, funct3, rd, opcode};
    endfunction

    // RV32I meaning of each funct3 in the arithmetic group
    function automatic logic [31:0] expected_value(input logic [2:0] funct3, input logic is_sub,
                                                   input logic [31:0] a, input logic [31:0] b);
        case (funct3)
            3'b000:  return is_sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [4:0] random_reg();
        logic [31:0] r;
        r = $random(seed);
        return (r[4:0] == 5'd0) ? 5'd1 : r[4:0]; // Never x0
    endfunction

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic execute_instr(input logic [31:0] word, input logic [31:0] pc_val,
                                 input logic [31:0] mem_val, input logic [31:0] expected,
                                 input string label);
        int waited;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
        pc          <= pc_val;
        mem_data    <= mem_val;
        @(posedge clk);
        instr_valid <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!done && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("no done pulse within 10 cycles for %s", label);
            errors++;
        end else begin
            check_word({"result ", label}, expected, result);
        end
        if (word[11:7] != 5'd0) model[word[11:7]] = expected; // x0 never changes
    endtask

    // add x0, xn, x0 shows xn on result without writing anything
    task automatic read_back(input logic [4:0] n);
        execute_instr(r_word(7'd0, 5'd0, n, 3'b000, 5'd0), 32'd0, 32'd0, model[n],
                      $sformatf("read x%0d", n));
    endtask

    task automatic report_test(input string name);
        if (errors == 0) begin
            $display("%-18s ok", name);
            tests_passed++;
        end else begin
            $display("%-18s FAILED with %0d errors", name, errors);
            tests_failed++;
        end
        errors = 0;
    endtask

    task automatic reset_values();
        @(negedge clk);
        check_word("busy", 32'd0, {31'd0, busy});
        check_word("done", 32'd0, {31'd0, done});
        check_word("result", 32'd0, result);
        for (int n = 0; n < 32; n++) read_back(n[4:0]);
        report_test("reset");
    endtask

    task automatic imm_arithmetic();
        logic [4:0]  rs1;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] r;
        for (int n = 1; n < 32; n++) begin
            r = $random(seed);
            execute_instr(i_word(t08_pkg::opcode_load, 12'd0, 5'd0, 3'b010, n[4:0]),
                          32'd0, r, r, "preload");
        end
        for (int i = 0; i < 15; i++) begin
            rs1 = random_reg();
            rd  = random_reg();
            f3  = imm_ops[3 * (i % 5) +: 3];
            r   = $random(seed);
            execute_instr(i_word(t08_pkg::opcode_op_imm, r[11:0], rs1, f3, rd), 32'd0, 32'd0,
                          expected_value(f3, 1'b0, model[rs1], {{20{r[11]}}, r[11:0]}), "i-type");
            read_back(rd);
        end
        report_test("i-type arithmetic");
    endtask

    task automatic reg_arithmetic();
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic [2:0] f3;
        logic       is_sub;
        execute_instr(i_word(t08_pkg::opcode_load, 12'd0, 5'd0, 3'b010, 5'd30), 32'd0,
                      32'h8000_0000, 32'h8000_0000, "load x30");
        execute_instr(i_word(t08_pkg::opcode_load, 12'd0, 5'd0, 3'b010, 5'd31), 32'd0,
                      32'd33, 32'd33, "load x31");
        execute_instr(r_word(7'd0, 5'd31, 5'd30, 3'b010, 5'd5), 32'd0, 32'd0, 32'd1, "slt sign");
        execute_instr(r_word(7'd0, 5'd31, 5'd30, 3'b101, 5'd6), 32'd0, 32'd0,
                      32'h4000_0000, "srl mask"); // 33 shifts by 1
        for (int i = 0; i < 24; i++) begin
            rs1    = random_reg();
            rs2    = random_reg();
            rd     = random_reg();
            f3     = reg_ops[3 * (i % 8) +: 3];
            is_sub = (i % 8 == 1);
            execute_instr(r_word(is_sub ? 7'b0100000 : 7'd0, rs2, rs1, f3, rd), 32'd0, 32'd0,
                          expected_value(f3, is_sub, model[rs1], model[rs2]), "r-type");
            read_back(rd);
        end
        report_test("r-type arithmetic");
    endtask

    task automatic write_sources();
        logic [4:0]  rd;
        logic [31:0] r;
        logic [31:0] pc_val;
        for (int i = 0; i < 3; i++) begin
            rd = random_reg();
            r  = $random(seed);
            execute_instr(i_word(t08_pkg::opcode_load, 12'd8, random_reg(), 3'b010, rd),
                          32'd0, r, r, "load");
            read_back(rd);
            rd     = random_reg();
            pc_val = $random(seed);
            pc_val = pc_val & 32'hffff_fffc;
            execute_instr({r[31:12], rd, t08_pkg::opcode_jal}, pc_val, 32'd0,
                          pc_val + 32'd4, "jal");
            read_back(rd);
        end
        report_test("write sources");
    endtask

    task automatic zero_register();
        logic [31:0] r;
        r = $random(seed);
        execute_instr(i_word(t08_pkg::opcode_op_imm, 12'h123, 5'd3, 3'b000, 5'd0), 32'd0, 32'd0,
                      model[3] + 32'h123, "addi x0");
        read_back(5'd0);
        execute_instr(i_word(t08_pkg::opcode_load, 12'd0, 5'd0, 3'b010, 5'd0), 32'd0, r, r,
                      "load x0");
        read_back(5'd0);
        execute_instr(r_word(7'd0, 5'd7, 5'd7, 3'b000, 5'd7), 32'd0, 32'd0,
                      model[7] + model[7], "add x7 x7 x7"); // Old value on both operands
        read_back(5'd7);
        execute_instr(r_word(7'b0100000, 5'd8, 5'd8, 3'b000, 5'd8), 32'd0, 32'd0, 32'd0,
                      "sub x8 x8 x8");
        read_back(5'd8);
        report_test("register zero");
    endtask

    task automatic busy_strobe();
        logic [31:0] expected;
        int          pulses;
        int          first;
        expected = model[4] + 32'd5;
        pulses   = 0;
        first    = 0;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= i_word(t08_pkg::opcode_op_imm, 12'd5, 5'd4, 3'b000, 5'd12);
        @(posedge clk);                                                    // Accepting edge
        instr    <= i_word(t08_pkg::opcode_load, 12'd0, 5'd0, 3'b010, 5'd13);
        mem_data <= 32'hdead_beef;
        for (int k = 1; k <= 8; k++) begin
            @(negedge clk);
            check_word("busy", (k <= 2) ? 32'd1 : 32'd0, {31'd0, busy}); // Read and execute
            if (done) begin
                pulses++;
                if (first == 0) first = k;
                check_word("result addi x12", expected, result);
            end
            if (k == 1) begin
                @(posedge clk); // Strobe still high, seen while busy
                instr_valid <= 1'b0;
            end
        end
        if (pulses != 1) begin
            $display("done pulsed %0d times for one accepted instruction", pulses);
            errors++;
        end
        check_word("done cycle", 32'd3, first);
        model[12] = expected;
        read_back(5'd13);
        read_back(5'd12);
        report_test("ignored strobe");
    endtask

    initial begin
        nRst        <= 1'b0;
        instr_valid <= 1'b0;
        instr       <= '0;
        pc          <= '0;
        mem_data    <= '0;
        for (int n = 0; n < 32; n++) model[n] = '0;
        repeat (4) @(posedge clk);
        nRst <= 1'b1;
        reset_values();
        imm_arithmetic();
        reg_arithmetic();
        write_sources();
        zero_register();
        busy_strobe();
        $display("summary: %0d ok, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
design/t08_pkg.sv
design/t08_alu.sv
design/t08_decoder.sv
design/t08_registers.sv
design/t08_sequencer.sv
design/t08_execute_unit.sv
tests/t08_execute_unit_tb.sv
